//--- common/rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// data and pc width
`define RV_XLEN 32

// imem word address width, 64 words
`define RV_IMEM_AW 6

// pc after reset
`define RV_RESET_PC 32'h0000_0000

`endif

//--- common/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_EQ,   // compares for branches
		ALU_NE,
		ALU_GE,
		ALU_GEU
	} alu_op_e;

	typedef enum logic [1:0] {
		WB_ALU,
		WB_IMM,
		WB_PC4
	} wb_sel_e;

	typedef enum logic [1:0] {
		BR_NONE,
		BR_BRANCH,
		BR_JAL,
		BR_JALR
	} br_kind_e;

endpackage

`default_nettype wire

//--- common/rv_pipe_pkg.sv
`default_nettype none

`include "rv_params.svh"

package rv_pipe_pkg;
	import rv_isa_pkg::*;

	typedef struct packed {
		logic [`RV_XLEN-1:0] pc;
		logic [31:0]         instr;
	} fd_pkt_t;

	typedef struct packed {
		logic [`RV_XLEN-1:0] pc;
		logic [4:0]          rs1;
		logic [4:0]          rs2;
		logic [4:0]          rd;
		logic [`RV_XLEN-1:0] rs1_val;
		logic [`RV_XLEN-1:0] rs2_val;
		logic [`RV_XLEN-1:0] imm;
		alu_op_e             alu_op;
		logic                op_b_imm;   // operand b from imm
		logic                op_a_pc;    // operand a from pc
		wb_sel_e             wb_sel;
		br_kind_e            br_kind;
		logic                reg_write;
	} de_pkt_t;

	typedef struct packed {
		logic [`RV_XLEN-1:0] pc;
		logic [4:0]          rd;
		logic                reg_write;
		logic [`RV_XLEN-1:0] result;
	} ew_pkt_t;

endpackage

`default_nettype wire

//--- common/stage_if.sv
`timescale 1ns/10ps
`default_nettype none

interface stage_if #(
	parameter type payload_t = logic
) ();
	logic     valid;
	payload_t payload;
	logic     hold;    // freeze, from the consumer side
	logic     flush;   // kill the register contents

	modport up (
		output valid,
		output payload,
		input  hold,
		input  flush
	);

	modport down (
		input  valid,
		input  payload,
		output hold,
		output flush
	);
endinterface

`default_nettype wire

//--- rtl/stage_reg.sv
`timescale 1ns/10ps
`default_nettype none

module stage_reg #(
	parameter type payload_t = logic
) (
	input  wire              clk,
	input  wire              rstn,
	input  wire              hold_i,
	input  wire              flush_i,
	input  wire              valid_i,
	input  wire payload_t    data_i,
	output logic             valid_o,
	output payload_t         data_o
);

	always_ff @(posedge clk or negedge rstn)
	begin
		if (!rstn)
			valid_o <= 1'b0;
		else if (!hold_i)
			valid_o <= valid_i && !flush_i;   // hold wins over flush
	end

	always_ff @(posedge clk)
	begin
		if (!hold_i)
			data_o <= data_i;
	end

	// a held slot keeps its contents across the edge
	a_hold_stable: assert property (
		@(posedge clk) disable iff (!rstn)
		hold_i |=> $stable(valid_o) && (!valid_o || $stable(data_o))
	);

endmodule

`default_nettype wire

//--- rtl/fetch_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_params.svh"

module fetch_stage
	import rv_pipe_pkg::*;
(
	input  wire                     clk,
	input  wire                     rstn,
	input  wire                     run_i,
	input  wire                     imem_we_i,
	input  wire [`RV_IMEM_AW-1:0]   imem_addr_i,
	input  wire [31:0]              imem_wdata_i,
	input  wire                     redir_valid_i,
	input  wire [`RV_XLEN-1:0]      redir_pc_i,
	stage_if.up                     fd_o
);

	logic [31:0]         imem [0:(1 << `RV_IMEM_AW)-1];
	logic [`RV_XLEN-1:0] pc_q;
	logic [31:0]         instr;
	fd_pkt_t             fd_d;

	assign instr = imem[pc_q[`RV_IMEM_AW+1:2]];   // word addressed, async read

	// host loads the program while the core is stopped
	always_ff @(posedge clk)
	begin
		if (imem_we_i && !run_i)
			imem[imem_addr_i] <= imem_wdata_i;
	end

	always_ff @(posedge clk or negedge rstn)
	begin
		if (!rstn)
			pc_q <= `RV_RESET_PC;
		else if (!fd_o.hold)
			pc_q <= redir_valid_i ? redir_pc_i : pc_q + `RV_XLEN'd4;
	end

	assign fd_d = '{pc: pc_q, instr: instr};

	stage_reg #(
		.payload_t (fd_pkt_t)
	) fd_reg (
		.clk     (clk),
		.rstn    (rstn),
		.hold_i  (fd_o.hold),
		.flush_i (fd_o.flush),
		.valid_i (1'b1),   // fetch always has an instruction
		.data_i  (fd_d),
		.valid_o (fd_o.valid),
		.data_o  (fd_o.payload)
	);

endmodule

`default_nettype wire

//--- rtl/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_params.svh"

module decode_stage
	import rv_isa_pkg::*, rv_pipe_pkg::*;
(
	input  wire                 clk,
	input  wire                 rstn,
	stage_if.down               fd_i,
	stage_if.up                 de_o,
	input  wire                 flush_i,
	input  wire                 wb_we_i,
	input  wire [4:0]           wb_rd_i,
	input  wire [`RV_XLEN-1:0]  wb_data_i
);

	fd_pkt_t             fd;
	de_pkt_t             de_d;
	logic [31:0]         instr;
	opcode_e             opc;
	logic [2:0]          funct3;
	logic [4:0]          rs1;
	logic [4:0]          rs2;
	logic [4:0]          rd;
	logic [`RV_XLEN-1:0] imm;
	logic [`RV_XLEN-1:0] rs1_val;
	logic [`RV_XLEN-1:0] rs2_val;
	logic [`RV_XLEN-1:0] rf [32];
	alu_op_e             alu_op;
	logic                op_b_imm;
	logic                op_a_pc;
	wb_sel_e             wb_sel;
	br_kind_e            br_kind;
	logic                reg_write;
	logic                known;

	function automatic alu_op_e alu_dec(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000:  return alt ? ALU_SUB : ALU_ADD;
			3'b001:  return ALU_SLL;
			3'b010:  return ALU_SLT;
			3'b011:  return ALU_SLTU;
			3'b100:  return ALU_XOR;
			3'b101:  return alt ? ALU_SRA : ALU_SRL;
			3'b110:  return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	assign fd_i.hold  = de_o.hold;
	assign fd_i.flush = flush_i;

	assign fd     = fd_i.payload;
	assign instr  = fd.instr;
	assign opc    = opcode_e'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign rs1    = instr[19:15];
	assign rs2    = instr[24:20];
	assign rd     = instr[11:7];

	always_comb
	begin
		case (opc)
			OPC_OP_IMM:
				if (funct3 == 3'b001 || funct3 == 3'b101)
					imm = {27'd0, instr[24:20]};   // shamt
				else
					imm = {{20{instr[31]}}, instr[31:20]};
			OPC_JALR:            imm = {{20{instr[31]}}, instr[31:20]};
			OPC_BRANCH:          imm = {{20{instr[31]}}, instr[7], instr[30:25],
			                            instr[11:8], 1'b0};
			OPC_LUI, OPC_AUIPC:  imm = {instr[31:12], 12'd0};
			OPC_JAL:             imm = {{12{instr[31]}}, instr[19:12], instr[20],
			                            instr[30:21], 1'b0};
			default:             imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};   // s type
		endcase
	end

	always_comb
	begin
		alu_op    = ALU_ADD;
		op_b_imm  = 1'b0;
		op_a_pc   = 1'b0;
		wb_sel    = WB_ALU;
		br_kind   = BR_NONE;
		reg_write = 1'b0;
		known     = 1'b1;
		case (opc)
			OPC_OP:
			begin
				alu_op    = alu_dec(funct3, instr[30]);
				reg_write = 1'b1;
			end
			OPC_OP_IMM:
			begin
				alu_op    = alu_dec(funct3, instr[30] && funct3 == 3'b101);   // no subi
				op_b_imm  = 1'b1;
				reg_write = 1'b1;
			end
			OPC_LUI:
			begin
				wb_sel    = WB_IMM;
				reg_write = 1'b1;
			end
			OPC_AUIPC:
			begin
				op_a_pc   = 1'b1;
				op_b_imm  = 1'b1;
				reg_write = 1'b1;
			end
			OPC_JAL:
			begin
				br_kind   = BR_JAL;
				wb_sel    = WB_PC4;
				reg_write = 1'b1;
			end
			OPC_JALR:
			begin
				br_kind   = BR_JALR;
				wb_sel    = WB_PC4;
				op_b_imm  = 1'b1;   // alu forms rs1 + imm
				reg_write = 1'b1;
			end
			OPC_BRANCH:
			begin
				br_kind = BR_BRANCH;
				case (funct3)
					3'b000:  alu_op = ALU_EQ;
					3'b001:  alu_op = ALU_NE;
					3'b100:  alu_op = ALU_SLT;
					3'b101:  alu_op = ALU_GE;
					3'b110:  alu_op = ALU_SLTU;
					3'b111:  alu_op = ALU_GEU;
					default: known  = 1'b0;
				endcase
			end
			default: known = 1'b0;   // becomes a bubble
		endcase
	end

	// register file, x0 is never stored
	always_ff @(posedge clk)
	begin
		if (wb_we_i && !de_o.hold && wb_rd_i != 5'd0)
			rf[wb_rd_i] <= wb_data_i;
	end

	assign rs1_val = (rs1 == 5'd0) ? '0 :
	                 (wb_we_i && wb_rd_i == rs1) ? wb_data_i : rf[rs1];   // write-through
	assign rs2_val = (rs2 == 5'd0) ? '0 :
	                 (wb_we_i && wb_rd_i == rs2) ? wb_data_i : rf[rs2];

	assign de_d = '{pc: fd.pc, rs1: rs1, rs2: rs2, rd: rd,
	                rs1_val: rs1_val, rs2_val: rs2_val, imm: imm,
	                alu_op: alu_op, op_b_imm: op_b_imm, op_a_pc: op_a_pc,
	                wb_sel: wb_sel, br_kind: br_kind, reg_write: reg_write};

	stage_reg #(
		.payload_t (de_pkt_t)
	) de_reg (
		.clk     (clk),
		.rstn    (rstn),
		.hold_i  (de_o.hold),
		.flush_i (de_o.flush),
		.valid_i (fd_i.valid && known),
		.data_i  (de_d),
		.valid_o (de_o.valid),
		.data_o  (de_o.payload)
	);

	// execute never puts a write to x0 on the writeback bus
	a_no_x0_write: assert property (
		@(posedge clk) disable iff (!rstn)
		wb_we_i |-> wb_rd_i != 5'd0
	);

endmodule

`default_nettype wire

//--- rtl/execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_params.svh"

module execute_stage
	import rv_isa_pkg::*, rv_pipe_pkg::*;
(
	input  wire                 clk,
	input  wire                 rstn,
	stage_if.down               de_i,
	stage_if.up                 ew_o,
	output logic                redir_valid_o,
	output logic [`RV_XLEN-1:0] redir_pc_o,
	output logic                wb_we_o,
	output logic [4:0]          wb_rd_o,
	output logic [`RV_XLEN-1:0] wb_data_o
);

	de_pkt_t             d;
	ew_pkt_t             ew_d;
	ew_pkt_t             ew_q;
	logic [`RV_XLEN-1:0] rs1_fwd;
	logic [`RV_XLEN-1:0] rs2_fwd;
	logic [`RV_XLEN-1:0] op_a;
	logic [`RV_XLEN-1:0] op_b;
	logic [`RV_XLEN-1:0] alu_res;
	logic [`RV_XLEN-1:0] result;
	logic [`RV_XLEN-1:0] br_target;
	logic                taken;
	logic                wr_en;

	assign d    = de_i.payload;
	assign ew_q = ew_o.payload;

	assign de_i.hold  = ew_o.hold;
	assign de_i.flush = redir_valid_o;

	// writeback bus straight from the E/W register
	assign wb_we_o   = ew_o.valid && ew_q.reg_write;
	assign wb_rd_o   = ew_q.rd;
	assign wb_data_o = ew_q.result;

	assign rs1_fwd = (wb_we_o && wb_rd_o != 5'd0 && wb_rd_o == d.rs1) ? wb_data_o : d.rs1_val;
	assign rs2_fwd = (wb_we_o && wb_rd_o != 5'd0 && wb_rd_o == d.rs2) ? wb_data_o : d.rs2_val;

	assign op_a = d.op_a_pc ? d.pc : rs1_fwd;
	assign op_b = d.op_b_imm ? d.imm : rs2_fwd;

	always_comb
	begin
		alu_res = '0;
		case (d.alu_op)
			ALU_ADD:  alu_res = op_a + op_b;
			ALU_SUB:  alu_res = op_a - op_b;
			ALU_SLL:  alu_res = op_a << op_b[4:0];
			ALU_SLT:  alu_res[0] = $signed(op_a) < $signed(op_b);
			ALU_SLTU: alu_res[0] = op_a < op_b;
			ALU_XOR:  alu_res = op_a ^ op_b;
			ALU_SRL:  alu_res = op_a >> op_b[4:0];
			ALU_SRA:  alu_res = $unsigned($signed(op_a) >>> op_b[4:0]);
			ALU_OR:   alu_res = op_a | op_b;
			ALU_AND:  alu_res = op_a & op_b;
			ALU_EQ:   alu_res[0] = op_a == op_b;
			ALU_NE:   alu_res[0] = op_a != op_b;
			ALU_GE:   alu_res[0] = $signed(op_a) >= $signed(op_b);
			default:  alu_res[0] = op_a >= op_b;   // geu
		endcase
	end

	always_comb
	begin
		case (d.br_kind)
			BR_BRANCH:      taken = alu_res[0];
			BR_JAL, BR_JALR: taken = 1'b1;
			default:        taken = 1'b0;
		endcase
	end

	assign br_target     = d.pc + d.imm;
	assign redir_valid_o = de_i.valid && taken;
	assign redir_pc_o    = (d.br_kind == BR_JALR) ? {alu_res[`RV_XLEN-1:1], 1'b0} : br_target;

	always_comb
	begin
		case (d.wb_sel)
			WB_IMM:  result = d.imm;
			WB_PC4:  result = d.pc + `RV_XLEN'd4;
			default: result = alu_res;
		endcase
	end

	// rd 0 retires as a non-writing instruction
	assign wr_en = d.reg_write && d.rd != 5'd0;
	assign ew_d  = '{pc: d.pc, rd: wr_en ? d.rd : 5'd0, reg_write: wr_en,
	                 result: wr_en ? result : '0};

	stage_reg #(
		.payload_t (ew_pkt_t)
	) ew_reg (
		.clk     (clk),
		.rstn    (rstn),
		.hold_i  (ew_o.hold),
		.flush_i (1'b0),
		.valid_i (de_i.valid),
		.data_i  (ew_d),
		.valid_o (ew_o.valid),
		.data_o  (ew_o.payload)
	);

	// the slot behind a redirect is flushed, so it can not redirect again
	a_no_redir_from_bubble: assert property (
		@(posedge clk) disable iff (!rstn)
		redir_valid_o && !de_i.hold |=> !redir_valid_o
	);

endmodule

`default_nettype wire

//--- rtl/rv_pipe_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_params.svh"

module rv_pipe_top
	import rv_pipe_pkg::*;
(
	input  wire                     clk,
	input  wire                     rstn,
	input  wire                     run_i,
	input  wire                     imem_we_i,
	input  wire [`RV_IMEM_AW-1:0]   imem_addr_i,
	input  wire [31:0]              imem_wdata_i,
	output logic                    retire_o,
	output logic [31:0]             retire_pc_o,
	output logic [4:0]              retire_rd_o,
	output logic [31:0]             retire_data_o
);

	stage_if #(.payload_t(fd_pkt_t)) fd_if ();
	stage_if #(.payload_t(de_pkt_t)) de_if ();
	stage_if #(.payload_t(ew_pkt_t)) ew_if ();

	logic                redir_valid;
	logic [`RV_XLEN-1:0] redir_pc;
	logic                wb_we;
	logic [4:0]          wb_rd;
	logic [`RV_XLEN-1:0] wb_data;

	assign ew_if.hold = ~run_i;   // propagates back through every stage

	fetch_stage fetch_i (
		.clk           (clk),
		.rstn          (rstn),
		.run_i         (run_i),
		.imem_we_i     (imem_we_i),
		.imem_addr_i   (imem_addr_i),
		.imem_wdata_i  (imem_wdata_i),
		.redir_valid_i (redir_valid),
		.redir_pc_i    (redir_pc),
		.fd_o          (fd_if.up)
	);

	decode_stage decode_i (
		.clk       (clk),
		.rstn      (rstn),
		.fd_i      (fd_if.down),
		.de_o      (de_if.up),
		.flush_i   (redir_valid),
		.wb_we_i   (wb_we),
		.wb_rd_i   (wb_rd),
		.wb_data_i (wb_data)
	);

	execute_stage execute_i (
		.clk           (clk),
		.rstn          (rstn),
		.de_i          (de_if.down),
		.ew_o          (ew_if.up),
		.redir_valid_o (redir_valid),
		.redir_pc_o    (redir_pc),
		.wb_we_o       (wb_we),
		.wb_rd_o       (wb_rd),
		.wb_data_o     (wb_data)
	);

	assign retire_o      = ew_if.valid && run_i;   // commits only on a running edge
	assign retire_pc_o   = ew_if.payload.pc;
	assign retire_rd_o   = ew_if.payload.rd;
	assign retire_data_o = ew_if.payload.result;

endmodule

`default_nettype wire

//--- tb/tb_iss.svh
`ifndef TB_ISS_SVH
`define TB_ISS_SVH

logic [31:0] iss_reg [32];
logic [31:0] iss_pc;

function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
	input logic [31:0] a, input logic [31:0] b);
	case (f3)
		3'b000:  return alt ? a - b : a + b;
		3'b001:  return a << b[4:0];
		3'b010:  return {31'd0, $signed(a) < $signed(b)};
		3'b011:  return {31'd0, a < b};
		3'b100:  return a ^ b;
		3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
		3'b110:  return a | b;
		default: return a & b;
	endcase
endfunction

function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
	input logic [31:0] b);
	case (f3)
		3'b000:  return a == b;
		3'b001:  return a != b;
		3'b100:  return $signed(a) < $signed(b);
		3'b101:  return $signed(a) >= $signed(b);
		3'b110:  return a < b;
		3'b111:  return a >= b;
		default: return 1'b0;
	endcase
endfunction

// runs the instruction at iss_pc and posts what it should retire with
task automatic iss_step();
	logic [31:0] ins;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] imm_i;
	logic [31:0] imm_b;
	logic [31:0] imm_j;
	logic [31:0] val;
	logic [31:0] next;
	logic [4:0]  rd;
	logic [2:0]  f3;
	logic        wr;
	ins   = prog[iss_pc[`RV_IMEM_AW+1:2]];
	rd    = ins[11:7];
	f3    = ins[14:12];
	a     = iss_reg[ins[19:15]];
	b     = iss_reg[ins[24:20]];
	imm_i = {{20{ins[31]}}, ins[31:20]};
	imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
	imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
	next  = iss_pc + 32'd4;
	wr    = 1'b1;
	val   = '0;
	case (ins[6:0])
		OPC_R:     val = alu_ref(f3, ins[30], a, b);
		OPC_I:     val = alu_ref(f3, ins[30] && f3 == 3'b101, a, imm_i);
		OPC_LUI:   val = {ins[31:12], 12'd0};
		OPC_AUIPC: val = iss_pc + {ins[31:12], 12'd0};
		OPC_JAL:
		begin
			val  = iss_pc + 32'd4;
			next = iss_pc + imm_j;
		end
		OPC_JALR:
		begin
			val  = iss_pc + 32'd4;
			next = (a + imm_i) & ~32'd1;
		end
		default:
		begin
			wr = 1'b0;   // branch
			if (branch_ref(f3, a, b))
				next = iss_pc + imm_b;
		end
	endcase
	if (wr && rd != 5'd0)
		iss_reg[rd] = val;
	exp_pc   <= iss_pc;
	exp_rd   <= (wr && rd != 5'd0) ? rd : 5'd0;
	exp_data <= (wr && rd != 5'd0) ? val : 32'd0;
	iss_pc = next;
endtask

`endif

//--- tb/rv_pipe_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_params.svh"

module rv_pipe_tb;

	localparam logic [6:0] OPC_R     = 7'b0110011;
	localparam logic [6:0] OPC_I     = 7'b0010011;
	localparam logic [6:0] OPC_LUI   = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC = 7'b0010111;
	localparam logic [6:0] OPC_B     = 7'b1100011;
	localparam logic [6:0] OPC_JAL   = 7'b1101111;
	localparam logic [6:0] OPC_JALR  = 7'b1100111;

	logic                   clk;
	logic                   rstn;
	logic                   run_i;
	logic                   imem_we_i;
	logic [`RV_IMEM_AW-1:0] imem_addr_i;
	logic [31:0]            imem_wdata_i;
	logic                   retire_o;
	logic [31:0]            retire_pc_o;
	logic [4:0]             retire_rd_o;
	logic [31:0]            retire_data_o;

	logic [31:0] prog [64];
	logic [31:0] exp_pc;
	logic [4:0]  exp_rd;
	logic [31:0] exp_data;
	int          wr_idx;
	int          seed;
	int          n_ret;
	int          loop_hits;
	logic [31:0] end_pc;

	`include "tb_iss.svh"

	rv_pipe_top dut_i (
		.clk           (clk),
		.rstn          (rstn),
		.run_i         (run_i),
		.imem_we_i     (imem_we_i),
		.imem_addr_i   (imem_addr_i),
		.imem_wdata_i  (imem_wdata_i),
		.retire_o      (retire_o),
		.retire_pc_o   (retire_pc_o),
		.retire_rd_o   (retire_rd_o),
		.retire_data_o (retire_data_o)
	);

	always #20 clk = ~clk;

	always @(posedge clk)
	begin
		if (rstn && retire_o)
			iss_step();
	end

	a_retire_match: assert property (
		@(posedge clk) disable iff (!rstn)
		retire_o |-> retire_pc_o == exp_pc && retire_rd_o == exp_rd && retire_data_o == exp_data
	)
	else
	begin
		$display("ERROR %0t: retire pc %h rd %0d data %h, model pc %h rd %0d data %h",
		         $time, retire_pc_o, retire_rd_o, retire_data_o, exp_pc, exp_rd, exp_data);
		$display("Regression failed");
		$fatal(1, "retire mismatch");
	end

	a_quiet_when_held: assert property (
		@(posedge clk) disable iff (!rstn)
		!run_i |-> !retire_o
	)
	else
	begin
		$display("ERROR %0t: retire seen while run is low", $time);
		$display("Regression failed");
		$fatal(1, "retire while held");
	end

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, OPC_R};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_B};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
	endfunction

	task automatic emit(input logic [31:0] w);
		prog[wr_idx] = w;
		wr_idx++;
	endtask

	task automatic build_program();
		logic [2:0]  kinds [6];
		logic [31:0] r;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [2:0]  f3;
		logic        alt;
		logic [11:0] fill;
		kinds = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
		wr_idx = 0;
		emit(enc_u(20'h12345, 5'd1, OPC_LUI));
		emit(enc_i(12'h678, 5'd1, 3'b000, 5'd1, OPC_I));
		emit(enc_i(12'hffb, 5'd0, 3'b000, 5'd2, OPC_I));   // x2 = -5
		emit(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
		emit(enc_r(7'h20, 5'd1, 5'd3, 3'b000, 5'd4));
		emit(enc_r(7'h00, 5'd2, 5'd2, 3'b001, 5'd5));
		emit(enc_r(7'h00, 5'd1, 5'd2, 3'b010, 5'd6));
		emit(enc_r(7'h00, 5'd1, 5'd2, 3'b011, 5'd7));
		emit(enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd8));
		emit(enc_r(7'h00, 5'd4, 5'd2, 3'b101, 5'd9));
		emit(enc_r(7'h20, 5'd4, 5'd2, 3'b101, 5'd10));
		emit(enc_r(7'h00, 5'd9, 5'd8, 3'b110, 5'd11));
		emit(enc_r(7'h00, 5'd1, 5'd11, 3'b111, 5'd12));
		emit(enc_i(12'h403, 5'd2, 3'b101, 5'd13, OPC_I));   // srai
		emit(enc_i(12'h003, 5'd2, 3'b101, 5'd14, OPC_I));
		emit(enc_i(12'h004, 5'd1, 3'b001, 5'd15, OPC_I));
		emit(enc_i(12'hfff, 5'd2, 3'b010, 5'd16, OPC_I));
		emit(enc_i(12'h007, 5'd2, 3'b011, 5'd17, OPC_I));
		emit(enc_i(12'h0f0, 5'd1, 3'b111, 5'd18, OPC_I));
		emit(enc_i(12'hfff, 5'd18, 3'b100, 5'd18, OPC_I));
		emit(enc_i(12'h00f, 5'd18, 3'b110, 5'd18, OPC_I));
		emit(enc_u(20'h00001, 5'd19, OPC_AUIPC));
		emit(enc_i(12'h005, 5'd1, 3'b000, 5'd0, OPC_I));   // x0 target
		emit(enc_u(20'habcde, 5'd0, OPC_LUI));
		// each branch kind taken once and not taken once, a taken one skips its addi
		foreach (kinds[k])
		begin
			if (kinds[k] < 3'b010)
			begin
				emit(enc_b(13'd8, 5'd1, 5'd1, kinds[k]));
				emit(enc_i(12'h001, 5'd0, 3'b000, 5'd19, OPC_I));
			end
			else
			begin
				emit(enc_b(13'd8, 5'd1, 5'd2, kinds[k]));
				emit(enc_i(12'h002, 5'd0, 3'b000, 5'd19, OPC_I));
			end
			emit(enc_b(13'd8, 5'd2, 5'd1, kinds[k]));
			emit(enc_i(12'h003, 5'd0, 3'b000, 5'd19, OPC_I));
		end
		emit(enc_j(21'd8, 5'd20));
		emit(enc_i(12'h004, 5'd0, 3'b000, 5'd19, OPC_I));
		emit(enc_u(20'h00000, 5'd21, OPC_AUIPC));
		emit(enc_i(12'd13, 5'd21, 3'b000, 5'd22, OPC_JALR));   // odd offset loses bit 0
		emit(enc_i(12'h005, 5'd0, 3'b000, 5'd19, OPC_I));
		for (int k = 0; k < 8; k++)
		begin
			r   = $random(seed);
			rd  = 5'd1 + r[4:0] % 5'd31;
			rs1 = 5'd1 + r[9:5] % 5'd18;   // only regs written above
			rs2 = 5'd1 + r[14:10] % 5'd18;
			f3  = r[17:15];
			alt = r[18] && (f3 == 3'b000 || f3 == 3'b101);
			if (r[19])
				emit(enc_r({1'b0, alt, 5'd0}, rs2, rs1, f3, rd));
			else if (f3 == 3'b001 || f3 == 3'b101)
				emit(enc_i({1'b0, alt, 5'd0, r[24:20]}, rs1, f3, rd, OPC_I));
			else
				emit(enc_i(r[31:20], rs1, f3, rd, OPC_I));
		end
		end_pc = wr_idx * 4;
		emit(enc_j(21'd0, 5'd0));   // park loop
		for (int i = wr_idx; i < 64; i++)
		begin
			fill    = 12'(i * 37);
			prog[i] = enc_i(fill, 5'd0, 3'b000, 5'd0, OPC_I);
		end
	endtask

	task automatic wait_retire(input int limit);
		int n;
		n = 0;
		while (!retire_o && n < limit)
		begin
			@(negedge clk);
			n++;
		end
		if (!retire_o)
		begin
			$display("timeout: no retire came within %0d cycles", limit);
			$display("Regression failed");
			$fatal(1, "retire timeout");
		end
	endtask

	task automatic pause_run();
		int len;
		len   = 1 + ($random(seed) & 7);
		run_i = 1'b0;
		repeat (len) @(negedge clk);
		run_i = 1'b1;
	endtask

	initial
	begin
		seed         = 41;
		clk          = 1'b0;
		rstn         = 1'b0;
		run_i        = 1'b0;
		imem_we_i    = 1'b0;
		imem_addr_i  = '0;
		imem_wdata_i = '0;
		n_ret        = 0;
		loop_hits    = 0;
		for (int i = 0; i < 32; i++)
			iss_reg[i] = '0;
		iss_pc = `RV_RESET_PC;
		build_program();
		repeat (2) @(negedge clk);
		rstn = 1'b1;
		for (int i = 0; i < 64; i++)
		begin
			@(negedge clk);
			imem_we_i    = 1'b1;
			imem_addr_i  = i[`RV_IMEM_AW-1:0];
			imem_wdata_i = prog[i];
		end
		@(negedge clk);
		imem_we_i = 1'b0;
		iss_step();   // first expected retire
		repeat (3) @(negedge clk);
		run_i = 1'b1;
		while (loop_hits < 3 && n_ret < 400)
		begin
			wait_retire(20);
			if (retire_pc_o == end_pc)
				loop_hits++;
			n_ret++;
			@(posedge clk);
			@(negedge clk);
			if (n_ret == 20 || n_ret == 45)
				pause_run();
		end
		if (loop_hits == 3)
		begin
			$display("Regression passed");
			$finish;
		end
		else
		begin
			$display("program never reached its final loop after %0d retires", n_ret);
			$display("Regression failed");
			$fatal(1, "end not reached");
		end
	end

endmodule

`default_nettype wire

//--- rv_pipe.f
+incdir+common
+incdir+tb
common/rv_isa_pkg.sv
common/rv_pipe_pkg.sv
common/stage_if.sv
rtl/stage_reg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/rv_pipe_top.sv
tb/rv_pipe_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f rv_pipe.f --top-module rv_pipe_tb -o rv_pipe_sim
./obj_dir/rv_pipe_sim | tee sim.log

if grep -q "Regression passed" sim.log; then
	echo "simulation ok"
else
	echo "simulation failed, see sim.log"
	exit 1
fi
